// File: src/umi_pkg.sv
/* UMI package with widths, command codes,
   the request/response packet struct and the unpacked local request struct */
package umi_pkg;

   //##############################
   // widths
   //##############################

   localparam int UMI_AW     = 32;   // address width
   localparam int UMI_DW     = 32;   // memory word width
   localparam int UMI_UW     = 256;  // packet width
   localparam int UMI_WORDS  = 4;    // max data words per packet
   localparam int UMI_CTRL_W = 32;   // cmd + size + options

   //##############################
   // command codes
   //##############################

   // bit 0 set marks a write request
   localparam logic [7:0] UMI_REQ_READ   = 8'h02;
   localparam logic [7:0] UMI_REQ_WRITE  = 8'h03;

   // every read is answered with this code
   localparam logic [7:0] UMI_RESP_WRITE = 8'h05;

   //##############################
   // packet layout
   //##############################

   // msb first; data word 0 sits in the lowest bits
   typedef struct packed {
      logic [UMI_UW-UMI_CTRL_W-2*UMI_AW-UMI_WORDS*UMI_DW-1:0] reserved; // 32 bits
      logic [7:0]                       cmd;
      logic [3:0]                       size;     // words minus one
      logic [19:0]                      options;
      logic [UMI_AW-1:0]                dstaddr;
      logic [UMI_AW-1:0]                srcaddr;
      logic [UMI_WORDS-1:0][UMI_DW-1:0] data;     // word 0 -> lowest address
   } umi_packet_t;

   //##############################
   // local request
   //##############################

   // what the memory sees of an accepted request
   typedef struct packed {
      logic [7:0]                       cmd;
      logic [3:0]                       size;
      logic [19:0]                      options;
      logic [UMI_AW-1:0]                addr;     // byte address
      logic [UMI_WORDS-1:0][UMI_DW-1:0] wrdata;
   } umi_fields_t;

endpackage

// File: src/umi_unpack.sv
/* request unpacker, splits a packet into local request fields
   and decodes the write flag from the command */
`timescale 1ns/1ps

module umi_unpack
  (
   input  umi_pkg::umi_packet_t       packet,   // incoming request
   output umi_pkg::umi_fields_t       fields,   // local request
   output logic [umi_pkg::UMI_AW-1:0] srcaddr,  // return address
   output logic                       write     // 1 = write, 0 = read
   );

   //##############################
   // field mapping
   //##############################

   always_comb
   begin
      fields.cmd     = packet.cmd;
      fields.size    = packet.size;      // words minus one
      fields.options = packet.options;
      fields.addr    = packet.dstaddr;   // target address in memory
      fields.wrdata  = packet.data;      // all four words, memory picks by size
   end

   // response goes back here
   assign srcaddr = packet.srcaddr;

   //##############################
   // command decode
   //##############################

   // only bit 0 matters
   // read and write codes differ there
   assign write = packet.cmd[0];

endmodule

// File: src/umi_pack.sv
/* response packer, builds a packet from return fields
   with the read word in data word 0 and zero fill elsewhere */
`timescale 1ns/1ps

module umi_pack
  (
   input  logic [7:0]                 cmd,
   input  logic [3:0]                 size,
   input  logic [19:0]                options,
   input  logic [umi_pkg::UMI_AW-1:0] dstaddr,   // requester's srcaddr
   input  logic [umi_pkg::UMI_AW-1:0] srcaddr,
   input  logic [umi_pkg::UMI_DW-1:0] rddata,    // single read word
   output umi_pkg::umi_packet_t       packet
   );

   always_comb
   begin
      // unused words and reserved bits go out as zero
      packet.reserved = '0;
      packet.data     = '0;

      // header
      packet.cmd      = cmd;
      packet.size     = size;      // echoed from the request
      packet.options  = options;
      packet.dstaddr  = dstaddr;
      packet.srcaddr  = srcaddr;

      // payload
      packet.data[0]  = rddata;
   end

endmodule

// File: src/umi_endpoint.sv
/* UMI endpoint, request accept and local strobes,
   registered read response with valid/ready control */
`timescale 1ns/1ps

module umi_endpoint
  (
   // ctrl
   input  logic                       clk,
   input  logic                       nreset,
   // device port, requests
   input  logic                       udev_req_valid,
   input  umi_pkg::umi_packet_t       udev_req_packet,
   output logic                       udev_req_ready,
   // device port, responses
   output logic                       udev_resp_valid,
   output umi_pkg::umi_packet_t       udev_resp_packet,
   input  logic                       udev_resp_ready,
   // local memory port
   output umi_pkg::umi_fields_t       loc_req,
   output logic                       loc_write,   // write strobe
   output logic                       loc_read,    // read strobe
   input  logic [umi_pkg::UMI_DW-1:0] loc_rddata,  // async read data
   input  logic                       loc_ready    // low during write beats
   );

   logic                       req_write;     // decoded from cmd
   logic [umi_pkg::UMI_AW-1:0] req_srcaddr;
   logic                       accept;        // request taken this cycle

   // response pipeline, payload only
   logic [umi_pkg::UMI_DW-1:0] rd_data_q;
   logic [umi_pkg::UMI_AW-1:0] dstaddr_q;
   logic [3:0]                 size_q;
   logic [19:0]                options_q;

   //##############################
   // request side
   //##############################

   umi_unpack u_unpack
     (
      .packet  (udev_req_packet),
      .fields  (loc_req),
      .srcaddr (req_srcaddr),
      .write   (req_write)
      );

   // stall on busy memory or on a response nobody takes
   assign udev_req_ready = loc_ready & udev_resp_ready;
   assign accept         = udev_req_valid & udev_req_ready;

   // strobes only fire on a taken request
   assign loc_write = accept &  req_write;
   assign loc_read  = accept & ~req_write;

   //##############################
   // response pipeline
   //##############################

   // loaded only by an accepted read
   always_ff @(posedge clk)
   begin
      if (loc_read)
      begin
         rd_data_q <= loc_rddata;             // memory answers same cycle
         dstaddr_q <= req_srcaddr;            // back to the requester
         size_q    <= loc_req.size;
         options_q <= loc_req.options;
      end
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         udev_resp_valid <= 1'b0;
      else if (loc_read)
         udev_resp_valid <= 1'b1;             // new response, old one consumed
      else if (udev_resp_valid & udev_resp_ready)
         udev_resp_valid <= 1'b0;
   end

   umi_pack u_pack
     (
      .cmd     (umi_pkg::UMI_RESP_WRITE),     // fixed response code
      .size    (size_q),
      .options (options_q),
      .dstaddr (dstaddr_q),
      .srcaddr ('0),                          // endpoint has no own address
      .rddata  (rd_data_q),
      .packet  (udev_resp_packet)
      );

   //##############################
   // checks
   //##############################

   // a stalled response must not move
   resp_stable_a : assert property (@(posedge clk) disable iff (!nreset)
      udev_resp_valid && !udev_resp_ready |=>
      udev_resp_valid && $stable(udev_resp_packet))
      else $error("response changed while stalled");

   strobe_excl_a : assert property (@(posedge clk) disable iff (!nreset)
      !(loc_read && loc_write))
      else $error("read and write strobes together");

   // unpacked size stays within four words
   req_size_a : assert property (@(posedge clk) disable iff (!nreset)
      udev_req_valid |-> loc_req.size <= 4'd3)
      else $error("request size above 3");

endmodule

// File: src/umi_word_mem.sv
/* local word memory, async read and multi-beat write sequencing
   that holds loc_ready low until all words of a write are stored */
`timescale 1ns/1ps

module umi_word_mem
  #(parameter int DEPTH = 256)   // words, power of two
  (
   input  logic                       clk,
   input  logic                       nreset,
   input  umi_pkg::umi_fields_t       loc_req,
   input  logic                       loc_write,
   input  logic                       loc_read,
   output logic [umi_pkg::UMI_DW-1:0] loc_rddata,
   output logic                       loc_ready
   );

   localparam int IDX_W    = $clog2(DEPTH);                  // word index bits
   localparam int BYTE_OFS = $clog2(umi_pkg::UMI_DW / 8);    // byte offset bits
   localparam int CNT_W    = $clog2(umi_pkg::UMI_WORDS);     // beats after word 0

   // storage
   logic [umi_pkg::UMI_DW-1:0] mem [DEPTH];

   logic [IDX_W-1:0] req_idx;    // word index of incoming request

   // write sequencer
   logic [CNT_W-1:0]                                    beat_cnt;   // words still to store
   logic                                                busy;
   logic [IDX_W-1:0]                                    next_idx;   // wraps mod DEPTH
   logic [umi_pkg::UMI_WORDS-2:0][umi_pkg::UMI_DW-1:0]  pend_words; // words 1..3, next in [0]

   //##############################
   // addressing and read
   //##############################

   // drop byte offset, upper bits alias
   assign req_idx = loc_req.addr[BYTE_OFS +: IDX_W];

   // async read, answered in the accept cycle
   assign loc_rddata = mem[req_idx];

   //##############################
   // write path
   //##############################

   always_ff @(posedge clk)
   begin
      if (loc_write)
         mem[req_idx] <= loc_req.wrdata[0];   // word 0 at once
      else if (busy)
         mem[next_idx] <= pend_words[0];     // one more word per cycle
   end

   // latched tail of a multi-word write
   always_ff @(posedge clk)
   begin
      if (loc_write)
      begin
         pend_words <= loc_req.wrdata[umi_pkg::UMI_WORDS-1:1];
         next_idx   <= req_idx + IDX_W'(1);
      end
      else if (busy)
      begin
         pend_words <= pend_words >> umi_pkg::UMI_DW;   // shift next word down
         next_idx   <= next_idx + IDX_W'(1);
      end
   end

   //##############################
   // beat count and ready
   //##############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         beat_cnt <= '0;
      else if (loc_write)
         beat_cnt <= loc_req.size[CNT_W-1:0];   // size s -> s extra beats
      else if (busy)
         beat_cnt <= beat_cnt - CNT_W'(1);
   end

   assign busy      = (beat_cnt != '0);
   assign loc_ready = ~busy;   // back up after exactly s cycles

   //##############################
   // checks
   //##############################

   // endpoint must gate its strobes with loc_ready
   no_strobe_busy_a : assert property (@(posedge clk) disable iff (!nreset)
      !loc_ready |-> !(loc_read || loc_write))
      else $error("strobe while memory busy");

endmodule

// File: src/umi_mem_subsys.sv
/* memory subsystem top, UMI endpoint in front of the word memory */
`timescale 1ns/1ps

module umi_mem_subsys
  #(parameter int DEPTH = 256)   // memory words
  (
   input  logic                 clk,
   input  logic                 nreset,
   // device port
   input  logic                 udev_req_valid,
   input  umi_pkg::umi_packet_t udev_req_packet,
   output logic                 udev_req_ready,
   output logic                 udev_resp_valid,
   output umi_pkg::umi_packet_t udev_resp_packet,
   input  logic                 udev_resp_ready
   );

   // local port between endpoint and memory
   umi_pkg::umi_fields_t       loc_req;
   logic                       loc_write;
   logic                       loc_read;
   logic [umi_pkg::UMI_DW-1:0] loc_rddata;
   logic                       loc_ready;

   umi_endpoint u_endpoint
     (
      .clk              (clk),
      .nreset           (nreset),
      .udev_req_valid   (udev_req_valid),
      .udev_req_packet  (udev_req_packet),
      .udev_req_ready   (udev_req_ready),
      .udev_resp_valid  (udev_resp_valid),
      .udev_resp_packet (udev_resp_packet),
      .udev_resp_ready  (udev_resp_ready),
      .loc_req          (loc_req),
      .loc_write        (loc_write),
      .loc_read         (loc_read),
      .loc_rddata       (loc_rddata),
      .loc_ready        (loc_ready)
      );

   umi_word_mem #(.DEPTH(DEPTH)) u_mem
     (
      .clk        (clk),
      .nreset     (nreset),
      .loc_req    (loc_req),
      .loc_write  (loc_write),
      .loc_read   (loc_read),
      .loc_rddata (loc_rddata),
      .loc_ready  (loc_ready)
      );

endmodule

// File: testbench/tb_umi_checks.svh
/* concurrent checks on the device port,
   the failure counter and its reporting task */

int errors = 0;   // failed checks

// bump the counter and print one failed check
task automatic count_failure(input string msg);
   errors = errors + 1;
   $display("CHECK FAILED at %0t: %s", $time, msg);
endtask

//##############################
// reset and flow control
//##############################

// first edge out of reset
rst_state_a : assert property (@(posedge clk)
   $rose(nreset) |-> !udev_resp_valid && udev_req_ready)
   else count_failure("state after reset");

// stalls on pending write beats or on a blocked response
ready_rule_a : assert property (@(posedge clk) disable iff (!nreset)
   udev_req_ready == (udev_resp_ready && busy_left == 4'd0))
   else count_failure("udev_req_ready");

//##############################
// response timing
//##############################

// read answered one cycle after accept
read_latency_a : assert property (@(posedge clk) disable iff (!nreset)
   acc_read |=> udev_resp_valid)
   else count_failure("no read response");

write_no_resp_a : assert property (@(posedge clk) disable iff (!nreset)
   acc_write |=> !udev_resp_valid)   // writes are silent
   else count_failure("write responded");

// stalled response frozen
resp_hold_a : assert property (@(posedge clk) disable iff (!nreset)
   udev_resp_valid && !udev_resp_ready |=> udev_resp_valid && $stable(udev_resp_packet))
   else count_failure("stalled response moved");

//##############################
// response content
//##############################

// consumed packet against the queue head in order
resp_match_a : assert property (@(posedge clk) disable iff (!nreset)
   udev_resp_valid && udev_resp_ready |-> exp_cnt != 0 && udev_resp_packet == exp_head)
   else count_failure("response packet");

// File: testbench/tb_umi_mem_subsys.sv
/* testbench for the memory subsystem, stimulus tasks,
   reference memory, expected response queue and test sequence */
`timescale 1ns/1ps

module tb_umi_mem_subsys;

   localparam int DEPTH        = 256;
   localparam int IDX_W        = $clog2(DEPTH);
   localparam int REQ_TIMEOUT  = 200;   // cycles per request
   localparam int DRAIN_TIMEOUT = 400;  // cycles to empty the queue

   logic                 clk;
   logic                 nreset          = 1'b0;
   logic                 udev_req_valid  = 1'b0;
   umi_pkg::umi_packet_t udev_req_packet = '0;
   logic                 udev_req_ready;
   logic                 udev_resp_valid;
   umi_pkg::umi_packet_t udev_resp_packet;
   logic                 udev_resp_ready = 1'b1;
   logic                 random_ready    = 1'b0;   // randomize resp ready
   integer               seed            = 32'h8a4085ac;

   // reference state
   logic [31:0]          mem_model [DEPTH];
   umi_pkg::umi_packet_t exp_q [$];                 // expected responses
   umi_pkg::umi_packet_t exp_head;                  // registered copy of queue front
   int                   exp_cnt;
   logic [3:0]           busy_left;                 // write beats still due
   int                   reads_acc;
   int                   writes_acc;
   int                   resps;
   int                   timeouts;
   logic                 acc_read;
   logic                 acc_write;

   assign acc_write = udev_req_valid && udev_req_ready
                      && udev_req_packet.cmd == umi_pkg::UMI_REQ_WRITE;
   assign acc_read  = udev_req_valid && udev_req_ready
                      && udev_req_packet.cmd == umi_pkg::UMI_REQ_READ;

   `include "tb_umi_checks.svh"

   umi_mem_subsys #(.DEPTH(DEPTH)) UUT
     (
      .clk              (clk),
      .nreset           (nreset),
      .udev_req_valid   (udev_req_valid),
      .udev_req_packet  (udev_req_packet),
      .udev_req_ready   (udev_req_ready),
      .udev_resp_valid  (udev_resp_valid),
      .udev_resp_packet (udev_resp_packet),
      .udev_resp_ready  (udev_resp_ready)
      );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   // mostly ready when randomized
   always @(posedge clk)
   begin
      if (random_ready)
         udev_resp_ready <= ($random(seed) & 3) != 0;
      else
         udev_resp_ready <= 1'b1;
   end

   // word index past the byte offset wraps mod DEPTH
   function automatic logic [IDX_W-1:0] word_index(input logic [31:0] addr, input int ofs);
      return IDX_W'((addr >> 2) + 32'(ofs));
   endfunction

   //##############################
   // reference model
   //##############################

   always @(posedge clk or negedge nreset)
   begin : monitor
      umi_pkg::umi_packet_t exp;
      int i;
      if (!nreset)
         busy_left <= 4'd0;
      else
      begin
         if (udev_resp_valid && udev_resp_ready)
         begin
            void'(exp_q.pop_front());   // pop before push for a same-edge read
            resps = resps + 1;
         end
         if (acc_write)
         begin
            for (i = 0; i <= int'(udev_req_packet.size); i++)
               mem_model[word_index(udev_req_packet.dstaddr, i)] = udev_req_packet.data[i[1:0]];
            busy_left  <= udev_req_packet.size;   // s extra beats
            writes_acc = writes_acc + 1;
         end
         else if (busy_left != 4'd0)
            busy_left <= busy_left - 4'd1;
         if (acc_read)
         begin
            exp         = '0;   // reserved and upper words zero
            exp.cmd     = umi_pkg::UMI_RESP_WRITE;
            exp.size    = udev_req_packet.size;
            exp.options = udev_req_packet.options;
            exp.dstaddr = udev_req_packet.srcaddr;
            exp.data[0] = mem_model[word_index(udev_req_packet.dstaddr, 0)];
            exp_q.push_back(exp);
            reads_acc = reads_acc + 1;
         end
         exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
         exp_cnt  <= exp_q.size();
      end
   end

   //##############################
   // stimulus tasks
   //##############################

   // drive one request and hold it until accepted
   task automatic send_req(input logic [7:0] cmd, input logic [3:0] size,
                           input logic [31:0] addr, input logic [31:0] src,
                           input logic [19:0] opts);
      umi_pkg::umi_packet_t p;
      int t;
      int k;
      p         = '0;
      p.cmd     = cmd;
      p.size    = size;
      p.options = opts;
      p.dstaddr = addr;
      p.srcaddr = src;
      if (cmd == umi_pkg::UMI_REQ_WRITE)
         for (k = 0; k < 4; k++)
            p.data[k[1:0]] = $random(seed);
      udev_req_valid  <= 1'b1;
      udev_req_packet <= p;
      t = 0;
      do
      begin
         @(negedge clk);   // ready settled here
         t++;
      end
      while (!udev_req_ready && t < REQ_TIMEOUT);
      if (!udev_req_ready)
      begin
         timeouts++;
         $display("timeout: request to %h not accepted in %0d cycles", addr, REQ_TIMEOUT);
      end
      @(posedge clk);   // accept edge
   endtask

   task automatic stop_req();
      udev_req_valid <= 1'b0;
   endtask

   // wait for every expected response to be consumed
   task automatic wait_drain(input string name);
      int t;
      t = 0;
      do
      begin
         @(negedge clk);
         t++;
      end
      while ((exp_q.size() != 0 || udev_resp_valid) && t < DRAIN_TIMEOUT);
      if (exp_q.size() != 0 || udev_resp_valid)
      begin
         timeouts++;
         $display("timeout: responses of %s still pending after %0d cycles", name, DRAIN_TIMEOUT);
      end
      @(posedge clk);
   endtask

   task automatic report_test(input int num, input string name);
      $display("test %0d %s done, %0d errors so far", num, name, errors);
   endtask

   //##############################
   // test sequence
   //##############################

   initial
   begin
      int n;
      reads_acc       = 0;
      writes_acc      = 0;
      resps           = 0;
      timeouts        = 0;
      repeat (16) @(posedge clk);
      nreset <= 1'b1;
      repeat (2) @(posedge clk);
      report_test(1, "reset state");

      send_req(umi_pkg::UMI_REQ_WRITE, 4'd0, 32'h40, 32'h0, 20'h0);
      send_req(umi_pkg::UMI_REQ_READ, 4'd0, 32'h40, 32'h1234_5600, 20'h5a5a5);
      stop_req();
      wait_drain("single word");
      report_test(2, "single word write and read");

      send_req(umi_pkg::UMI_REQ_WRITE, 4'd3, 32'h80, 32'h0, 20'h0);
      send_req(umi_pkg::UMI_REQ_WRITE, 4'd3, 32'((DEPTH - 2) * 4), 32'h0, 20'h0);   // wraps
      for (n = 0; n < 4; n++)
         send_req(umi_pkg::UMI_REQ_READ, 4'(n), 32'h80 + 32'(n * 4), 32'h100 + 32'(n), 20'h1);
      for (n = 0; n < 4; n++)
         send_req(umi_pkg::UMI_REQ_READ, 4'd0, 32'(((DEPTH - 2 + n) % DEPTH) * 4),
                  32'h200 + 32'(n), 20'h2);
      send_req(umi_pkg::UMI_REQ_READ, 4'd0, 32'(DEPTH * 4), 32'h300, 20'h3);   // alias of 0
      stop_req();
      wait_drain("four word write");
      report_test(3, "four word write with wrap");

      send_req(umi_pkg::UMI_REQ_WRITE, 4'd1, 32'h10, 32'h0, 20'h0);
      send_req(umi_pkg::UMI_REQ_WRITE, 4'd2, 32'h20, 32'h0, 20'h0);
      send_req(umi_pkg::UMI_REQ_WRITE, 4'd0, 32'h30, 32'h0, 20'h0);
      stop_req();
      wait_drain("silent writes");
      report_test(4, "writes without response");

      random_ready <= 1'b1;
      send_req(umi_pkg::UMI_REQ_WRITE, 4'd3, 32'h200, 32'h0, 20'h0);
      send_req(umi_pkg::UMI_REQ_WRITE, 4'd3, 32'h210, 32'h0, 20'h0);
      for (n = 0; n < 24; n++)
         send_req(umi_pkg::UMI_REQ_READ, 4'($random(seed) & 3),
                  32'h200 + 32'(($random(seed) & 7) << 2), 32'($random(seed)),
                  20'($random(seed)));
      stop_req();
      wait_drain("random ready");
      random_ready <= 1'b0;
      report_test(5, "back-to-back reads with random ready");

      // every accepted read answered once
      resp_count_a : assert (resps == reads_acc)
         else count_failure($sformatf("%0d reads but %0d responses", reads_acc, resps));
      $display("reads %0d, writes %0d, responses %0d, errors %0d, timeouts %0d",
               reads_acc, writes_acc, resps, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// File: flist.f
+incdir+testbench
src/umi_pkg.sv
src/umi_unpack.sv
src/umi_pack.sv
src/umi_endpoint.sv
src/umi_word_mem.sv
src/umi_mem_subsys.sv
testbench/tb_umi_mem_subsys.sv

// File: run.sh
#!/bin/sh
# compile and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_umi_mem_subsys

out=$(./obj_dir/Vtb_umi_mem_subsys)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1
